// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu (
    exec_if.alu ex
);
    localparam int W = rv_isa_pkg::XLEN;

    logic [W-1:0]   a;
    logic [W-1:0]   b;
    logic [4:0]     shamt;
    logic [W-1:0]   sum;
    // Comparators shared by SLT(U) and the branches
    logic           eq;
    logic           lt_s;
    logic           lt_u;
    logic [2*W-1:0] prod_ss;
    logic [2*W-1:0] prod_su;
    logic [2*W-1:0] prod_uu;
    logic           div_zero;
    logic           div_ovf;
    logic [W-1:0]   sra_res;
    logic [W-1:0]   int_res;
    logic [W-1:0]   md_res;
    logic           f7_base;
    logic           f7_alt;
    logic           f7_md;
    logic [W-1:0]   res;
    logic           take;
    logic           bad;

    assign a     = ex.in1;
    assign b     = ex.in2;
    assign shamt = b[4:0];
    // One adder for ADD, AUIPC, jumps and addresses
    assign sum   = a + b;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    // Sign or zero extend before multiply so the upper half is exact
    assign prod_ss = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};
    assign prod_su = {{W{a[W-1]}}, a} * {{W{1'b0}}, b};
    assign prod_uu = {{W{1'b0}}, a} * {{W{1'b0}}, b};

    assign div_zero = (b == '0);
    // Most negative value divided by -1
    assign div_ovf  = (a == {1'b1, {(W-1){1'b0}}}) && (b == '1);

    // Kept apart so the shift stays arithmetic
    assign sra_res = $signed(a) >>> shamt;

    assign f7_base = (ex.funct_7 == rv_isa_pkg::BASE);
    assign f7_alt  = (ex.funct_7 == rv_isa_pkg::ALT);
    assign f7_md   = (ex.funct_7 == rv_isa_pkg::MULDIV);

    // Integer ops common to OP and OP-IMM
    always_comb begin
        case (ex.funct_3)
            // SUB only exists in the register form
            rv_isa_pkg::ADD_SUB: int_res = (ex.op == rv_isa_pkg::OP && f7_alt) ? a - b : sum;
            rv_isa_pkg::SLL:     int_res = a << shamt;
            rv_isa_pkg::SLT:     int_res = {{(W-1){1'b0}}, lt_s};
            rv_isa_pkg::SLTU:    int_res = {{(W-1){1'b0}}, lt_u};
            rv_isa_pkg::XOR:     int_res = a ^ b;
            rv_isa_pkg::SRL_SRA: int_res = f7_alt ? sra_res : a >> shamt;
            rv_isa_pkg::OR:      int_res = a | b;
            default:             int_res = a & b;
        endcase
    end

    // M extension, divide corner cases per the ISA
    always_comb begin
        case (ex.funct_3)
            rv_isa_pkg::ADD_SUB: md_res = prod_uu[W-1:0];
            rv_isa_pkg::SLL:     md_res = prod_ss[2*W-1:W];
            rv_isa_pkg::SLT:     md_res = prod_su[2*W-1:W];
            rv_isa_pkg::SLTU:    md_res = prod_uu[2*W-1:W];
            rv_isa_pkg::XOR: begin
                if (div_zero)     md_res = '1;
                else if (div_ovf) md_res = a;
                else              md_res = $signed(a) / $signed(b);
            end
            rv_isa_pkg::SRL_SRA: md_res = div_zero ? '1 : a / b;
            rv_isa_pkg::OR: begin
                if (div_zero)     md_res = a;
                else if (div_ovf) md_res = '0;
                else              md_res = $signed(a) % $signed(b);
            end
            default:             md_res = div_zero ? a : a % b;
        endcase
    end

    // Opcode level result, jump flag and legality
    always_comb begin
        res  = '0;
        take = 1'b0;
        bad  = 1'b0;
        case (ex.op)
            rv_isa_pkg::LUI:   res = b;
            rv_isa_pkg::AUIPC: res = sum;
            rv_isa_pkg::OP_IMM: begin
                res = int_res;
                // Immediate shifts carry funct7 in imm[11:5]
                if (ex.funct_3 == rv_isa_pkg::SLL && !f7_base) begin
                    bad = 1'b1;
                end
                if (ex.funct_3 == rv_isa_pkg::SRL_SRA && !(f7_base || f7_alt)) begin
                    bad = 1'b1;
                end
            end
            rv_isa_pkg::OP: begin
                if (f7_md) begin
                    res = md_res;
                end else if (f7_base || (f7_alt && ex.funct_3 inside
                             {rv_isa_pkg::ADD_SUB, rv_isa_pkg::SRL_SRA})) begin
                    res = int_res;
                end else begin
                    bad = 1'b1;
                end
            end
            rv_isa_pkg::JAL: begin
                res  = sum;
                take = 1'b1;
            end
            rv_isa_pkg::JALR: begin
                // Target LSB forced low
                res  = sum & {{(W-1){1'b1}}, 1'b0};
                take = 1'b1;
                bad  = (ex.funct_3 != 3'b000);
            end
            rv_isa_pkg::BRANCH: begin
                // Target comes from a separate adder, out stays 0
                case (ex.funct_3)
                    rv_isa_pkg::BEQ:  take = eq;
                    rv_isa_pkg::BNE:  take = !eq;
                    rv_isa_pkg::BLT:  take = lt_s;
                    rv_isa_pkg::BGE:  take = !lt_s;
                    rv_isa_pkg::BLTU: take = lt_u;
                    rv_isa_pkg::BGEU: take = !lt_u;
                    default:          bad  = 1'b1;
                endcase
            end
            rv_isa_pkg::LOAD: begin
                res = sum;
                // LB LH LW LBU LHU
                bad = !(ex.funct_3 inside {rv_isa_pkg::ADD_SUB, rv_isa_pkg::SLL,
                        rv_isa_pkg::SLT, rv_isa_pkg::XOR, rv_isa_pkg::SRL_SRA});
            end
            rv_isa_pkg::STORE: begin
                res = sum;
                // SB SH SW
                bad = !(ex.funct_3 inside {rv_isa_pkg::ADD_SUB, rv_isa_pkg::SLL,
                        rv_isa_pkg::SLT});
            end
            default: bad = 1'b1;
        endcase
    end

    // Any illegal encoding forces both outputs low
    assign ex.out     = bad ? '0 : res;
    assign ex.pc_sel  = take && !bad;
    assign ex.illegal = bad;

    // Only control transfers may redirect the PC
    a_pc_sel_ctrl: assert property (@(posedge ex.clk)
        ex.pc_sel |-> ex.op inside {rv_isa_pkg::JAL, rv_isa_pkg::JALR, rv_isa_pkg::BRANCH});

    a_illegal_no_jump: assert property (@(posedge ex.clk)
        ex.illegal |-> !ex.pc_sel);

endmodule

// ==== design/apb_exec_regs.sv ====
`timescale 1ns/10ps

module apb_exec_regs #(
    parameter int APB_ADDR_WIDTH = 8
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    exec_if.regs                      ex,
    output logic [31:0]               pc,
    output logic [31:0]               rs1,
    output logic [31:0]               rs2,
    output logic [31:0]               instr
);
    exec_regs_pkg::reg_addr_e addr;
    logic                     access;
    logic                     mapped;
    logic                     read_only;
    logic                     wr_en;
    logic [31:0]              rd_data;
    logic [31:0]              result;
    logic [31:0]              status;
    logic                     done;
    logic                     pending;
    logic                     pc_sel_q;
    logic                     illegal_q;

    // Upper address bits alias onto the map
    assign addr   = exec_regs_pkg::reg_addr_e'(paddr[4:0]);
    assign access = psel && penable;

    always_comb begin
        status = '0;
        status[exec_regs_pkg::STATUS_DONE]    = done;
        status[exec_regs_pkg::STATUS_PC_SEL]  = pc_sel_q;
        status[exec_regs_pkg::STATUS_ILLEGAL] = illegal_q;
    end

    // Address decode and read mux
    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        rd_data   = '0;
        case (addr)
            exec_regs_pkg::PC:    rd_data = pc;
            exec_regs_pkg::RS1:   rd_data = rs1;
            exec_regs_pkg::RS2:   rd_data = rs2;
            exec_regs_pkg::INSTR: rd_data = instr;
            exec_regs_pkg::RESULT: begin
                rd_data   = result;
                read_only = 1'b1;
            end
            exec_regs_pkg::STATUS: begin
                rd_data   = status;
                read_only = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    // No wait states
    assign pready  = 1'b1;
    assign wr_en   = access && pwrite && mapped && !read_only;
    // Error on unmapped access or write to a read-only register
    assign pslverr = access && (!mapped || (pwrite && read_only));
    // Read data is live from setup through access
    assign prdata  = (psel && !pwrite) ? rd_data : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= '0;
            rs1       <= '0;
            rs2       <= '0;
            instr     <= '0;
            result    <= '0;
            pc_sel_q  <= 1'b0;
            illegal_q <= 1'b0;
            done      <= 1'b0;
            pending   <= 1'b0;
        end else begin
            // One cycle after INSTR write the ALU has settled
            if (pending) begin
                result    <= ex.out;
                pc_sel_q  <= ex.pc_sel;
                illegal_q <= ex.illegal;
                done      <= 1'b1;
                pending   <= 1'b0;
            end
            if (wr_en) begin
                case (addr)
                    exec_regs_pkg::PC:  pc  <= pwdata;
                    exec_regs_pkg::RS1: rs1 <= pwdata;
                    exec_regs_pkg::RS2: rs2 <= pwdata;
                    exec_regs_pkg::INSTR: begin
                        // New instruction restarts the sequence
                        instr   <= pwdata;
                        done    <= 1'b0;
                        pending <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> psel);

    a_done_after_pending: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(done) |-> $past(pending));

endmodule

// ==== design/exec_if.sv ====
`timescale 1ns/10ps

interface exec_if (
    input logic clk
);
    // Decoded operands
    logic [rv_isa_pkg::XLEN-1:0] in1;
    logic [rv_isa_pkg::XLEN-1:0] in2;
    rv_isa_pkg::opcode_e         op;
    logic [2:0]                  funct_3;
    logic [6:0]                  funct_7;

    // ALU results
    logic [rv_isa_pkg::XLEN-1:0] out;
    logic                        pc_sel;
    logic                        illegal;

    modport decoder (
        output in1, in2, op, funct_3, funct_7
    );

    // Clock only samples the ALU checks
    modport alu (
        input  clk, in1, in2, op, funct_3, funct_7,
        output out, pc_sel, illegal
    );

    modport regs (
        input out, pc_sel, illegal
    );

endinterface

// ==== design/exec_regs_pkg.sv ====
package exec_regs_pkg;

    // Byte offsets of the execute unit registers
    // Only paddr[4:0] takes part in decoding
    typedef enum logic [4:0] {
        PC     = 5'h00,
        RS1    = 5'h04,
        RS2    = 5'h08,
        // Write starts execution
        INSTR  = 5'h0C,
        // Read only
        RESULT = 5'h10,
        STATUS = 5'h14
    } reg_addr_e;

    // STATUS bit positions
    parameter int STATUS_DONE    = 0;
    parameter int STATUS_PC_SEL  = 1;
    parameter int STATUS_ILLEGAL = 2;

endpackage

// ==== design/exec_top.sv ====
`timescale 1ns/10ps

module exec_top #(
    parameter int APB_ADDR_WIDTH = 8
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);
    // Stored operands and instruction word
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] instr;

    // Decoder to ALU to register block
    exec_if u_ex (
        .clk (clk)
    );

    apb_exec_regs #(
        .APB_ADDR_WIDTH (APB_ADDR_WIDTH)
    ) u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ex      (u_ex),
        .pc      (pc),
        .rs1     (rs1),
        .rs2     (rs2),
        .instr   (instr)
    );

    inst_decode u_dec (
        .pc    (pc),
        .rs1   (rs1),
        .rs2   (rs2),
        .instr (instr),
        .ex    (u_ex)
    );

    alu u_alu (
        .ex (u_ex)
    );

endmodule

// ==== design/inst_decode.sv ====
`timescale 1ns/10ps

module inst_decode (
    input  logic [rv_isa_pkg::XLEN-1:0] pc,
    input  logic [rv_isa_pkg::XLEN-1:0] rs1,
    input  logic [rv_isa_pkg::XLEN-1:0] rs2,
    input  logic [rv_isa_pkg::XLEN-1:0] instr,
    exec_if.decoder                     ex
);
    localparam int W = rv_isa_pkg::XLEN;

    rv_isa_pkg::opcode_e opc;
    logic [W-1:0]        imm_i;
    logic [W-1:0]        imm_s;
    logic [W-1:0]        imm_u;
    logic [W-1:0]        imm_j;
    logic [W-1:0]        imm;

    // Unknown opcodes pass through to the ALU, which flags them
    assign opc = rv_isa_pkg::opcode_e'(instr[6:0]);

    // I format for JALR, loads and OP-IMM
    // For shifts imm[4:0] is shamt and imm[11:5] is funct7
    assign imm_i = {{(W-12){instr[31]}}, instr[31:20]};
    // S format split around the rd field
    assign imm_s = {{(W-12){instr[31]}}, instr[31:25], instr[11:7]};
    // U format fills the upper 20 bits
    assign imm_u = {instr[31:12], 12'b0};
    // J format with bit 0 always clear
    assign imm_j = {{(W-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // Immediate format chosen by opcode
    always_comb begin
        case (opc)
            rv_isa_pkg::LUI,
            rv_isa_pkg::AUIPC:  imm = imm_u;
            rv_isa_pkg::JAL:    imm = imm_j;
            rv_isa_pkg::STORE:  imm = imm_s;
            default:            imm = imm_i;
        endcase
    end

    assign ex.op      = opc;
    assign ex.funct_3 = instr[14:12];
    // Same bits as imm[11:5] for OP-IMM shifts
    assign ex.funct_7 = instr[31:25];

    // PC relative forms take the PC
    assign ex.in1 = (opc == rv_isa_pkg::AUIPC || opc == rv_isa_pkg::JAL) ? pc : rs1;
    // Register-register and compares take rs2
    assign ex.in2 = (opc == rv_isa_pkg::OP || opc == rv_isa_pkg::BRANCH) ? rs2 : imm;

endmodule

// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Data width, fixed because shift amounts use five bits
    parameter int XLEN = 32;

    // Major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    // funct3 codes named by their OP / OP-IMM meaning
    // Loads and stores reuse the same values for size
    //   LB/SB 000, LH/SH 001, LW/SW 010, LBU 100, LHU 101
    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } funct3_e;

    // Branch conditions, 010 and 011 are reserved
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_e;

    // funct7 values accepted by OP
    // ALT selects SUB and SRA, MULDIV selects the M extension
    typedef enum logic [6:0] {
        BASE   = 7'b0000000,
        MULDIV = 7'b0000001,
        ALT    = 7'b0100000
    } funct7_e;

endpackage

// ==== sources.f ====
design/rv_isa_pkg.sv
design/exec_regs_pkg.sv
design/exec_if.sv
design/inst_decode.sv
design/alu.sv
design/apb_exec_regs.sv
design/exec_top.sv
test/tb_clock_gen.sv
test/exec_tb.sv

// ==== test/exec_tb.sv ====
`timescale 1ns/10ps

module exec_tb;

    localparam int REPS = 4;
    // Register access, RV32I, M extension, control flow, illegal with recovery
    localparam int N_TESTS    = 2 + 84 + 56 + 44 + 24;
    localparam int MAX_CYCLES = 20 * N_TESTS + 100;

    // Register offsets
    localparam logic [7:0] A_PC     = 8'h00;
    localparam logic [7:0] A_RS1    = 8'h04;
    localparam logic [7:0] A_RS2    = 8'h08;
    localparam logic [7:0] A_INSTR  = 8'h0C;
    localparam logic [7:0] A_RESULT = 8'h10;
    localparam logic [7:0] A_STATUS = 8'h14;

    // Operand pairs equal, less and greater, then two where signed and unsigned order differ
    localparam logic [31:0] BR_A [5] = '{32'd5, 32'd3, 32'd9, 32'hffff_fff0, 32'd7};
    localparam logic [31:0] BR_B [5] = '{32'd5, 32'd9, 32'd3, 32'd7, 32'hffff_fff0};

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Observed values waiting for the compare process
    string       chk_name_q[$];
    logic [31:0] chk_exp_q[$];
    logic [31:0] chk_act_q[$];
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycles = 0;

    tb_clock_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    exec_top DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // RV32I integer result where alt_sub and alt_sra pick SUB and SRA
    function automatic logic [31:0] int_ref(input logic [2:0] f3, input logic alt_sub,
                                           input logic alt_sra, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];
        case (f3)
            3'd0: r = alt_sub ? a - b : a + b;
            3'd1: r = a << sh;
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt_sra) r = $signed(a) >>> sh;
                else r = a >> sh;
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // M extension result with the ISA rules for zero divisor and overflow
    function automatic logic [31:0] muldiv_ref(input logic [2:0] f3, input logic [31:0] a,
                                              input logic [31:0] b);
        longint          sa;
        longint          sb;
        longint          ub;
        longint unsigned ua;
        longint unsigned ubu;
        int              qa;
        int              qb;
        logic [63:0]     p;
        logic            ovf;
        logic [31:0]     r;
        sa  = $signed(a);
        sb  = $signed(b);
        ub  = b;
        ua  = a;
        ubu = b;
        qa  = a;
        qb  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f3)
            3'd0: begin
                p = sa * sb;
                r = p[31:0];
            end
            3'd1: begin
                p = sa * sb;
                r = p[63:32];
            end
            3'd2: begin
                p = sa * ub;
                r = p[63:32];
            end
            3'd3: begin
                p = ua * ubu;
                r = p[63:32];
            end
            3'd4: begin
                if (b == 0) r = 32'hffff_ffff;
                else if (ovf) r = a;
                else r = qa / qb;
            end
            3'd5: begin
                if (b == 0) r = 32'hffff_ffff;
                else r = a / b;
            end
            3'd6: begin
                if (b == 0) r = a;
                else if (ovf) r = 32'h0;
                else r = qa % qb;
            end
            default: begin
                if (b == 0) r = a;
                else r = a % b;
            end
        endcase
        return r;
    endfunction

    // Expected {illegal, pc_sel, result} for one instruction
    function automatic logic [33:0] ref_exec(input logic [31:0] pc, input logic [31:0] a,
                                            input logic [31:0] b, input logic [31:0] ins);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] r;
        logic        take;
        logic        ill;
        opc   = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        imm_i = 32'($signed(ins[31:20]));
        imm_s = 32'($signed({ins[31:25], ins[11:7]}));
        imm_u = {ins[31:12], 12'h000};
        imm_j = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        r     = '0;
        take  = 1'b0;
        ill   = 1'b0;
        case (opc)
            // LUI and AUIPC
            7'h37: r = imm_u;
            7'h17: r = pc + imm_u;
            7'h13: begin
                // Shift immediates carry funct7 in imm[11:5]
                if ((f3 == 3'd1 && f7 != 7'h00) ||
                    (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
                    ill = 1'b1;
                end else begin
                    r = int_ref(f3, 1'b0, f7 == 7'h20, a, imm_i);
                end
            end
            7'h33: begin
                if (f7 == 7'h01) r = muldiv_ref(f3, a, b);
                else if (f7 == 7'h00) r = int_ref(f3, 1'b0, 1'b0, a, b);
                else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))
                    r = int_ref(f3, 1'b1, 1'b1, a, b);
                else ill = 1'b1;
            end
            7'h6f: begin
                r    = pc + imm_j;
                take = 1'b1;
            end
            7'h67: begin
                r    = (a + imm_i) & ~32'd1;
                take = 1'b1;
                ill  = (f3 != 3'd0);
            end
            7'h63: begin
                case (f3)
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = !($signed(a) < $signed(b));
                    3'd6: take = (a < b);
                    3'd7: take = !(a < b);
                    default: ill = 1'b1;
                endcase
            end
            // Loads LB LH LW LBU LHU and stores SB SH SW
            7'h03: begin
                r   = a + imm_i;
                ill = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            end
            7'h23: begin
                r   = a + imm_s;
                ill = (f3 > 3'd2);
            end
            default: ill = 1'b1;
        endcase
        if (ill) begin
            r    = '0;
            take = 1'b0;
        end
        return {ill, take, r};
    endfunction

    // Random word with opcode, funct3 and funct7 fields forced
    function automatic logic [31:0] mk_instr(input logic [6:0] opc, input logic [2:0] f3,
                                            input logic [6:0] f7);
        logic [31:0] w;
        w        = $urandom;
        w[6:0]   = opc;
        w[14:12] = f3;
        w[31:25] = f7;
        return w;
    endfunction

    // One APB transfer entered and left 1 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic exp_err, input logic chk_rd,
                            input logic [31:0] exp_rd, input string name);
        logic [31:0] rd;
        logic        err;
        logic        rdy;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // Access phase outputs sampled mid cycle since pready stays high
        @(negedge clk);
        rd  = prdata;
        err = pslverr;
        rdy = pready;
        chk_name_q.push_back("pready");
        chk_exp_q.push_back(32'h1);
        chk_act_q.push_back({31'b0, rdy});
        chk_name_q.push_back($sformatf("pslverr at 0x%h", addr));
        chk_exp_q.push_back({31'b0, exp_err});
        chk_act_q.push_back({31'b0, err});
        if (chk_rd) begin
            chk_name_q.push_back(name);
            chk_exp_q.push_back(exp_rd);
            chk_act_q.push_back(rd);
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        apb_xfer(1'b1, addr, data, exp_err, 1'b0, '0, "");
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp, input string name);
        apb_xfer(1'b0, addr, '0, 1'b0, 1'b1, exp, name);
    endtask

    // Load operands and instruction and read back the captured results
    task automatic run_instr(input logic [31:0] pc_v, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] ins);
        logic [33:0] exp;
        exp = ref_exec(pc_v, a, b, ins);
        apb_write(A_PC, pc_v, 1'b0);
        apb_write(A_RS1, a, 1'b0);
        apb_write(A_RS2, b, 1'b0);
        apb_write(A_INSTR, ins, 1'b0);
        apb_read(A_RESULT, exp[31:0], "RESULT");
        // DONE in bit 0 with pc_sel and illegal above it
        apb_read(A_STATUS, {29'b0, exp[33], exp[32], 1'b1}, "STATUS");
    endtask

    // Checks run one edge after the values were captured
    always @(posedge clk) begin : compare
        string       name;
        logic [31:0] e;
        logic [31:0] a;
        while (chk_act_q.size() > 0) begin
            name = chk_name_q.pop_front();
            e    = chk_exp_q.pop_front();
            a    = chk_act_q.pop_front();
            n_checks++;
            if (a !== e) begin
                n_errors++;
                $display("mismatch %s: expected 0x%h, got 0x%h", name, e, a);
            end
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        logic [31:0] v;
        logic [31:0] ins;
        logic [6:0]  f7;
        logic [31:0] bad_q[$];
        int          i;
        int          k;
        void'($urandom(32'hcc1caf18));
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        wait (arst_n === 1'b1);
        @(posedge clk);
        #1;

        // Reset values and register readback
        apb_read(A_RESULT, 32'h0, "RESULT");
        apb_read(A_STATUS, 32'h0, "STATUS");
        v = $urandom;
        apb_write(A_PC, v, 1'b0);
        apb_read(A_PC, v, "PC");
        v = $urandom;
        apb_write(A_RS1, v, 1'b0);
        apb_read(A_RS1, v, "RS1");
        v = $urandom;
        apb_write(A_RS2, v, 1'b0);
        apb_read(A_RS2, v, "RS2");
        // Unmapped offsets and read-only targets
        apb_xfer(1'b0, 8'h18, '0, 1'b1, 1'b0, '0, "");
        apb_xfer(1'b1, 8'h1C, $urandom, 1'b1, 1'b0, '0, "");
        apb_write(A_RESULT, 32'h5a5a_a5a5, 1'b1);
        apb_write(A_STATUS, 32'h0000_0007, 1'b1);
        apb_read(A_RESULT, 32'h0, "RESULT");
        apb_read(A_STATUS, 32'h0, "STATUS");

        // RV32I register and immediate forms
        for (k = 0; k < REPS; k++) begin
            for (i = 0; i < 8; i++) begin
                run_instr($urandom, $urandom, $urandom, mk_instr(7'h33, i[2:0], 7'h00));
                // Shift immediates need a valid funct7 while the rest take random bits
                f7 = (i == 1 || i == 5) ? 7'h00 : 7'($urandom);
                run_instr($urandom, $urandom, $urandom, mk_instr(7'h13, i[2:0], f7));
            end
            run_instr($urandom, $urandom, $urandom, mk_instr(7'h33, 3'd0, 7'h20));
            run_instr($urandom, $urandom, $urandom, mk_instr(7'h33, 3'd5, 7'h20));
            run_instr($urandom, $urandom, $urandom, mk_instr(7'h13, 3'd5, 7'h20));
            run_instr($urandom, $urandom, $urandom, mk_instr(7'h37, 3'($urandom), 7'($urandom)));
            run_instr($urandom, $urandom, $urandom, mk_instr(7'h17, 3'($urandom), 7'($urandom)));
        end

        // M extension with random then corner operands
        for (k = 0; k < REPS; k++) begin
            for (i = 0; i < 8; i++) begin
                run_instr($urandom, $urandom, $urandom, mk_instr(7'h33, i[2:0], 7'h01));
            end
        end
        for (i = 0; i < 8; i++) begin
            ins = mk_instr(7'h33, i[2:0], 7'h01);
            run_instr($urandom, $urandom, 32'h0, ins);
            run_instr($urandom, 32'h8000_0000, 32'hffff_ffff, ins);
            // Negative times negative shows the high-half signedness
            run_instr($urandom, 32'hffff_fffd, 32'h8000_0001, ins);
        end

        // Branches, jumps and address sums
        for (i = 0; i < 8; i++) begin
            if (i != 2 && i != 3) begin
                for (k = 0; k < 5; k++) begin
                    run_instr($urandom, BR_A[k], BR_B[k], mk_instr(7'h63, i[2:0], 7'($urandom)));
                end
            end
        end
        for (k = 0; k < 3; k++) begin
            run_instr($urandom, $urandom, $urandom, mk_instr(7'h6f, 3'($urandom), 7'($urandom)));
            run_instr($urandom, $urandom, $urandom, mk_instr(7'h67, 3'd0, 7'($urandom)));
        end
        for (i = 0; i < 8; i++) begin
            if (i != 3 && i < 6) begin
                run_instr($urandom, $urandom, $urandom, mk_instr(7'h03, i[2:0], 7'($urandom)));
            end
            if (i < 3) begin
                run_instr($urandom, $urandom, $urandom, mk_instr(7'h23, i[2:0], 7'($urandom)));
            end
        end

        // Illegal encodings each followed by a plain ADD
        bad_q.push_back(mk_instr(7'h33, 3'd1, 7'h20));
        bad_q.push_back(mk_instr(7'h33, 3'($urandom), 7'h02));
        bad_q.push_back(mk_instr(7'h33, 3'd4, 7'h40));
        bad_q.push_back(mk_instr(7'h13, 3'd1, 7'h20));
        bad_q.push_back(mk_instr(7'h13, 3'd5, 7'h01));
        bad_q.push_back(mk_instr(7'h7f, 3'($urandom), 7'($urandom)));
        bad_q.push_back(mk_instr(7'h0b, 3'($urandom), 7'($urandom)));
        bad_q.push_back(mk_instr(7'h63, 3'd2, 7'($urandom)));
        bad_q.push_back(mk_instr(7'h63, 3'd3, 7'($urandom)));
        bad_q.push_back(mk_instr(7'h67, 3'd1, 7'($urandom)));
        bad_q.push_back(mk_instr(7'h03, 3'd3, 7'($urandom)));
        bad_q.push_back(mk_instr(7'h23, 3'd4, 7'($urandom)));
        foreach (bad_q[j]) begin
            run_instr($urandom, $urandom, $urandom, bad_q[j]);
            run_instr($urandom, $urandom, $urandom, mk_instr(7'h33, 3'd0, 7'h00));
        end

        // Let the compare process drain
        repeat (2) @(negedge clk);
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && n_checks > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low over the first three rising edges
    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule
